//--- common/reg_pkg.sv
package reg_pkg;

    // bus widths, fixed so the structs below have a known size
    parameter int ADDR_W = 16;
    parameter int DATA_W = 32;

    // address bit 15 set means the access goes out on the external port
    parameter int EXT_SEL_BIT = 15;

    // read-only identification word at internal register 0
    parameter logic [DATA_W-1:0] REG_ID_VALUE = 32'h5253_0100;

    // read data carried by every error acknowledge
    parameter logic [DATA_W-1:0] ERR_DATA = 32'hBAD0_BAD0;

    // request toward the register side, 50 bits
    typedef struct packed {
        logic              rd_en;
        logic              wr_en;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wr_data;
    } reg_req_t;

    // response from the register side, 34 bits
    // ack_vld is a one-cycle pulse, err only valid with it
    typedef struct packed {
        logic              ack_vld;
        logic              err;
        logic [DATA_W-1:0] rd_data;
    } reg_rsp_t;

endpackage

//--- slv_fsm/slv_fsm.sv
`timescale 1ns/100ps

module slv_fsm (
    input  logic             clk,
    input  logic             rstn,
    input  logic             req_vld,
    input  reg_pkg::reg_req_t mst_req,
    input  logic             sync_reset,
    input  reg_pkg::reg_rsp_t slv_rsp,
    input  logic             ext_selected,
    output logic             slv_req_vld,
    output reg_pkg::reg_req_t slv_req,
    output reg_pkg::reg_rsp_t mst_rsp,
    output logic             idle
);

    typedef enum logic {
        S_IDLE,
        S_WAIT_ACK
    } state_t;

    state_t state;
    state_t next_state;

    // request taken this cycle
    logic accept;

    // latched request
    logic                      rd_en_q;
    logic                      wr_en_q;
    logic [reg_pkg::ADDR_W-1:0] addr_q;
    logic [reg_pkg::DATA_W-1:0] wr_data_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= S_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // sync_reset wins over everything, a new strobe only counts in idle
    always_comb begin
        case (state)
            S_IDLE: begin
                next_state = (req_vld && !sync_reset) ? S_WAIT_ACK : S_IDLE;
            end
            S_WAIT_ACK: begin
                next_state = (sync_reset || slv_rsp.ack_vld) ? S_IDLE : S_WAIT_ACK;
            end
            default: begin
                next_state = S_IDLE;
            end
        endcase
    end

    assign accept = (state == S_IDLE) && (next_state == S_WAIT_ACK);

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q    <= mst_req.addr;
            wr_data_q <= mst_req.wr_data;
        end
    end

    // enables held through the wait only for the external port,
    // the internal file samples them on the first cycle
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rd_en_q <= 1'b0;
            wr_en_q <= 1'b0;
        end else if (accept) begin
            rd_en_q <= mst_req.rd_en;
            wr_en_q <= mst_req.wr_en;
        end else if (next_state == S_WAIT_ACK) begin
            rd_en_q <= rd_en_q & ext_selected;
            wr_en_q <= wr_en_q & ext_selected;
        end else begin
            rd_en_q <= 1'b0;
            wr_en_q <= 1'b0;
        end
    end

    assign slv_req_vld = (state == S_WAIT_ACK);
    assign idle        = (state == S_IDLE);

    // register side sees zeros while idle
    always_comb begin
        if (state == S_IDLE) begin
            slv_req = '0;
        end else begin
            slv_req = '{rd_en: rd_en_q, wr_en: wr_en_q, addr: addr_q, wr_data: wr_data_q};
        end
    end

    always_comb begin
        mst_rsp.ack_vld = slv_rsp.ack_vld;
        mst_rsp.err     = slv_rsp.err;
        mst_rsp.rd_data = slv_rsp.ack_vld ? slv_rsp.rd_data : '0;
    end

    // master must never ask for a read and a write in one access
    a_no_rd_wr: assert property (
        @(posedge clk) disable iff (!rstn) !(slv_req.rd_en && slv_req.wr_en)
    );

endmodule

//--- verilog/ack_timer.sv
`timescale 1ns/100ps

module ack_timer #(
    parameter int TIMEOUT_CYCLES = 16
) (
    input  logic clk,
    input  logic rstn,
    input  logic count_en,
    input  logic sync_reset,
    output logic timeout
);

    // one extra count so the counter parks past the compare value
    localparam int CNT_W = $clog2(TIMEOUT_CYCLES + 2);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cnt <= '0;
        end else if (sync_reset || !count_en) begin
            cnt <= '0;
        end else if (cnt != CNT_W'(TIMEOUT_CYCLES + 1)) begin
            cnt <= cnt + 1'b1;
        end
    end

    // cnt equals cycles since count_en rose, so this fires once
    assign timeout = count_en && (cnt == CNT_W'(TIMEOUT_CYCLES));

    // timeout needs an access that has been open since the previous cycle
    a_timeout_in_access: assert property (
        @(posedge clk) disable iff (!rstn) timeout |-> count_en && $past(count_en)
    );

endmodule

//--- verilog/reg_decoder.sv
`timescale 1ns/100ps

module reg_decoder (
    input  logic             slv_req_vld,
    input  reg_pkg::reg_req_t slv_req,
    input  reg_pkg::reg_rsp_t int_rsp,
    input  reg_pkg::reg_rsp_t ext_rsp,
    input  logic             timeout,
    output logic             int_req_vld,
    output logic             ext_req_vld,
    output reg_pkg::reg_req_t ext_req,
    output logic             ext_selected,
    output reg_pkg::reg_rsp_t slv_rsp
);

    // external ack only counts while its request is open
    logic ext_ack;

    assign ext_selected = slv_req.addr[reg_pkg::EXT_SEL_BIT];

    assign int_req_vld = slv_req_vld & ~ext_selected;
    assign ext_req_vld = slv_req_vld & ext_selected;

    // nothing leaks out of the top for internal accesses
    assign ext_req = ext_selected ? slv_req : '0;

    assign ext_ack = ext_rsp.ack_vld & ext_req_vld;

    // external first, then timeout, then internal
    always_comb begin
        if (ext_ack) begin
            slv_rsp = ext_rsp;
        end else if (timeout) begin
            slv_rsp = '{ack_vld: 1'b1, err: 1'b1, rd_data: reg_pkg::ERR_DATA};
        end else if (int_rsp.ack_vld) begin
            slv_rsp = int_rsp;
        end else begin
            slv_rsp = '0;
        end
    end

endmodule

//--- verilog/int_reg_file.sv
`timescale 1ns/100ps

module int_reg_file #(
    parameter int NUM_REGS = 8
) (
    input  logic             clk,
    input  logic             rstn,
    input  logic             req_vld,
    input  reg_pkg::reg_req_t req,
    input  logic             sync_reset,
    output reg_pkg::reg_rsp_t rsp
);

    localparam int IDX_W = $clog2(NUM_REGS);

    // register 0 is the ID word, so storage starts at 1
    logic [reg_pkg::DATA_W-1:0] regs [1:NUM_REGS-1];

    logic                      req_vld_q;
    logic                      first;
    logic                      in_range;
    logic [IDX_W-1:0]          idx;
    logic [reg_pkg::DATA_W-1:0] rd_word;

    // word addressed, the two low address bits are ignored
    assign idx      = req.addr[IDX_W+1:2];
    assign in_range = req.addr[reg_pkg::ADDR_W-1:2] < (reg_pkg::ADDR_W-2)'(NUM_REGS);

    // rising edge of req_vld marks a new request
    assign first = req_vld & ~req_vld_q;

    assign rd_word = (idx == '0) ? reg_pkg::REG_ID_VALUE : regs[idx];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            req_vld_q <= 1'b0;
            rsp       <= '0;
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (sync_reset) begin
            req_vld_q <= 1'b0;
            rsp       <= '0;
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            req_vld_q <= req_vld;
            rsp       <= '0;
            if (first) begin
                rsp.ack_vld <= 1'b1;
                if (!in_range) begin
                    rsp.err     <= 1'b1;
                    rsp.rd_data <= reg_pkg::ERR_DATA;
                end else if (req.wr_en) begin
                    // writes to the ID register are dropped
                    if (idx != '0) begin
                        regs[idx] <= req.wr_data;
                    end
                end else begin
                    rsp.rd_data <= rd_word;
                end
            end
        end
    end

    // one ack per request, the fsm drops req_vld right after it
    a_single_ack: assert property (
        @(posedge clk) disable iff (!rstn) rsp.ack_vld |=> !rsp.ack_vld
    );

endmodule

//--- verilog/reg_slv_top.sv
`timescale 1ns/100ps

module reg_slv_top #(
    parameter int NUM_REGS       = 8,
    parameter int TIMEOUT_CYCLES = 16
) (
    input  logic             clk,
    input  logic             rstn,
    input  logic             req_vld,
    input  reg_pkg::reg_req_t mst_req,
    input  logic             sync_reset,
    output reg_pkg::reg_rsp_t mst_rsp,
    output logic             idle,
    output logic             ext_req_vld,
    output reg_pkg::reg_req_t ext_req,
    input  reg_pkg::reg_rsp_t ext_rsp
);

    logic             slv_req_vld;
    reg_pkg::reg_req_t slv_req;
    reg_pkg::reg_rsp_t slv_rsp;
    logic             ext_selected;
    logic             int_req_vld;
    reg_pkg::reg_rsp_t int_rsp;
    logic             timeout;

    slv_fsm u_slv_fsm (
        .clk         (clk),
        .rstn        (rstn),
        .req_vld     (req_vld),
        .mst_req     (mst_req),
        .sync_reset  (sync_reset),
        .slv_rsp     (slv_rsp),
        .ext_selected(ext_selected),
        .slv_req_vld (slv_req_vld),
        .slv_req     (slv_req),
        .mst_rsp     (mst_rsp),
        .idle        (idle)
    );

    reg_decoder u_reg_decoder (
        .slv_req_vld (slv_req_vld),
        .slv_req     (slv_req),
        .int_rsp     (int_rsp),
        .ext_rsp     (ext_rsp),
        .timeout     (timeout),
        .int_req_vld (int_req_vld),
        .ext_req_vld (ext_req_vld),
        .ext_req     (ext_req),
        .ext_selected(ext_selected),
        .slv_rsp     (slv_rsp)
    );

    int_reg_file #(.NUM_REGS(NUM_REGS)) u_int_reg_file (
        .clk       (clk),
        .rstn      (rstn),
        .req_vld   (int_req_vld),
        .req       (slv_req),
        .sync_reset(sync_reset),
        .rsp       (int_rsp)
    );

    // timer runs for as long as the external request is open
    ack_timer #(.TIMEOUT_CYCLES(TIMEOUT_CYCLES)) u_ack_timer (
        .clk       (clk),
        .rstn      (rstn),
        .count_en  (ext_req_vld),
        .sync_reset(sync_reset),
        .timeout   (timeout)
    );

endmodule

//--- sim/tb_reg_slv.sv
`timescale 1ns/100ps

module tb_reg_slv;

    localparam int NUM_REGS       = 8;
    localparam int TIMEOUT_CYCLES = 16;
    localparam int ACK_LIMIT      = TIMEOUT_CYCLES + 8;
    localparam int NUM_ROWS       = 21;
    localparam int OP_RD          = 0;
    localparam int OP_WR          = 1;
    localparam int OP_SYNC        = 2;
    localparam int NEVER          = -1;

    // exp_data only used when from_model is clear
    typedef struct packed {
        int          op;
        logic [15:0] addr;
        logic [31:0] wr_data;
        logic        rnd;
        int          delay;
        logic        from_model;
        logic [31:0] exp_data;
        logic        exp_err;
    } row_t;

    logic              clk;
    logic              rstn;
    logic              req_vld;
    reg_pkg::reg_req_t mst_req;
    logic              sync_reset;
    reg_pkg::reg_rsp_t mst_rsp;
    logic              idle;
    logic              ext_req_vld;
    reg_pkg::reg_req_t ext_req;
    reg_pkg::reg_rsp_t ext_rsp;

    row_t        rows [0:NUM_ROWS-1];
    logic [31:0] sb [0:NUM_REGS-1];
    logic [31:0] ext_mem [0:255];
    integer      seed;

    reg_slv_top #(.NUM_REGS(NUM_REGS), .TIMEOUT_CYCLES(TIMEOUT_CYCLES)) u_dut (
        .clk        (clk),
        .rstn       (rstn),
        .req_vld    (req_vld),
        .mst_req    (mst_req),
        .sync_reset (sync_reset),
        .mst_rsp    (mst_rsp),
        .idle       (idle),
        .ext_req_vld(ext_req_vld),
        .ext_req    (ext_req),
        .ext_rsp    (ext_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else
            stop_with_error($sformatf("Mismatch at %0t ns: %s = %h, expected %h",
                                      $time, name, got, exp));
    endtask

    // op, addr, wr_data, rnd, ext delay, from_model, exp_data, exp_err
    task automatic load_table();
        rows[0]  = '{OP_WR,   16'h0004, 32'h0,         1'b1, 0,     1'b1, 32'h0,         1'b0};
        rows[1]  = '{OP_RD,   16'h0004, 32'h0,         1'b0, 0,     1'b1, 32'h0,         1'b0};
        rows[2]  = '{OP_WR,   16'h001C, 32'h1234_5678, 1'b0, 0,     1'b0, 32'h0,         1'b0};
        rows[3]  = '{OP_RD,   16'h001C, 32'h0,         1'b0, 0,     1'b0, 32'h1234_5678, 1'b0};
        rows[4]  = '{OP_RD,   16'h0000, 32'h0,         1'b0, 0,     1'b0, 32'h5253_0100, 1'b0};
        rows[5]  = '{OP_WR,   16'h0000, 32'hFFFF_FFFF, 1'b0, 0,     1'b0, 32'h0,         1'b0};
        rows[6]  = '{OP_RD,   16'h0000, 32'h0,         1'b0, 0,     1'b0, 32'h5253_0100, 1'b0};
        rows[7]  = '{OP_RD,   16'h0020, 32'h0,         1'b0, 0,     1'b0, 32'hBAD0_BAD0, 1'b1};
        rows[8]  = '{OP_WR,   16'h0100, 32'h5555_AAAA, 1'b0, 0,     1'b0, 32'hBAD0_BAD0, 1'b1};
        rows[9]  = '{OP_WR,   16'h8010, 32'h0,         1'b1, 0,     1'b1, 32'h0,         1'b0};
        rows[10] = '{OP_RD,   16'h8010, 32'h0,         1'b0, 3,     1'b1, 32'h0,         1'b0};
        rows[11] = '{OP_RD,   16'h8024, 32'h0,         1'b0, 12,    1'b1, 32'h0,         1'b0};
        rows[12] = '{OP_WR,   16'h8024, 32'hCAFE_F00D, 1'b0, 7,     1'b0, 32'h0,         1'b0};
        rows[13] = '{OP_RD,   16'h8024, 32'h0,         1'b0, 1,     1'b0, 32'hCAFE_F00D, 1'b0};
        rows[14] = '{OP_RD,   16'h8040, 32'h0,         1'b0, NEVER, 1'b0, 32'hBAD0_BAD0, 1'b1};
        rows[15] = '{OP_WR,   16'h8044, 32'h1111_2222, 1'b0, NEVER, 1'b0, 32'hBAD0_BAD0, 1'b1};
        rows[16] = '{OP_SYNC, 16'h8050, 32'h0,         1'b0, NEVER, 1'b0, 32'h0,         1'b0};
        rows[17] = '{OP_RD,   16'h0004, 32'h0,         1'b0, 0,     1'b0, 32'h0,         1'b0};
        rows[18] = '{OP_RD,   16'h001C, 32'h0,         1'b0, 0,     1'b0, 32'h0,         1'b0};
        rows[19] = '{OP_RD,   16'h0000, 32'h0,         1'b0, 0,     1'b0, 32'h5253_0100, 1'b0};
        rows[20] = '{OP_RD,   16'h8060, 32'h0,         1'b0, NEVER, 1'b0, 32'hBAD0_BAD0, 1'b1};
    endtask

    // expected read data from the register rules and the external memory
    function automatic logic [31:0] model_data(input row_t r);
        if (r.exp_err) return reg_pkg::ERR_DATA;
        if (r.op == OP_WR) return '0;
        if (r.addr[15]) return ext_mem[r.addr[9:2]];
        if (r.addr[14:2] == '0) return reg_pkg::REG_ID_VALUE;
        return sb[r.addr[4:2]];
    endfunction

    // one access, the external slave is modelled inside the wait loop
    task automatic run_access(input row_t r, input logic [31:0] wdata,
                              output logic [31:0] rd_data, output logic err);
        int cycles;
        int ext_cycles;
        int ext_rise;
        cycles     = 0;
        ext_cycles = 0;
        ext_rise   = -1;
        req_vld    = 1'b1;
        mst_req    = '{rd_en: r.op == OP_RD, wr_en: r.op == OP_WR, addr: r.addr, wr_data: wdata};
        forever begin
            @(negedge clk);
            cycles++;
            req_vld = 1'b0;
            mst_req = '0;
            ext_rsp = '0;
            if (ext_req_vld && ext_rise < 0) ext_rise = cycles;
            if (!r.addr[15]) begin
                assert (!ext_req_vld && ext_req == '0) else
                    stop_with_error("external port active during an internal access");
            end
            if (ext_req_vld) begin
                // enables held for the whole external access
                check_value("ext_req.rd_en", 32'(ext_req.rd_en), 32'(r.op == OP_RD));
                check_value("ext_req.wr_en", 32'(ext_req.wr_en), 32'(r.op == OP_WR));
            end
            if (ext_req_vld && r.delay != NEVER) begin
                if (ext_cycles == r.delay) begin
                    check_value("ext_req.addr", 32'(ext_req.addr), 32'(r.addr));
                    if (r.op == OP_WR) check_value("ext_req.wr_data", ext_req.wr_data, wdata);
                    ext_rsp.ack_vld = 1'b1;
                    if (ext_req.wr_en) ext_mem[ext_req.addr[9:2]] = ext_req.wr_data;
                    else ext_rsp.rd_data = ext_mem[ext_req.addr[9:2]];
                end
                ext_cycles++;
            end
            #1;
            if (mst_rsp.ack_vld) break;
            check_value("mst_rsp.rd_data", mst_rsp.rd_data, 32'h0);
            assert (cycles < ACK_LIMIT) else
                stop_with_error($sformatf("no acknowledge for address %h", r.addr));
        end
        rd_data = mst_rsp.rd_data;
        err     = mst_rsp.err;
        if (!r.addr[15]) check_value("internal ack cycles", 32'(cycles), 32'd2);
        else if (r.delay == NEVER)
            check_value("timeout ack cycles", 32'(cycles - ext_rise), 32'(TIMEOUT_CYCLES));
        else check_value("external ack cycles", 32'(cycles), 32'(1 + r.delay));
        @(negedge clk);
        assert (idle && !mst_rsp.ack_vld) else
            stop_with_error("DUT did not return to idle after a one-cycle acknowledge");
        ext_rsp = '0;
    endtask

    // sync reset while an unanswered external read is open
    task automatic apply_sync_reset(input row_t r);
        req_vld = 1'b1;
        mst_req = '{rd_en: 1'b1, wr_en: 1'b0, addr: r.addr, wr_data: '0};
        @(negedge clk);
        req_vld = 1'b0;
        mst_req = '0;
        @(negedge clk);
        assert (!idle && ext_req_vld) else stop_with_error("external access not open");
        sync_reset = 1'b1;
        @(negedge clk);
        sync_reset = 1'b0;
        assert (idle && !ext_req_vld) else stop_with_error("sync reset did not return to idle");
        for (int i = 0; i < NUM_REGS; i++) sb[i] = '0;
    endtask

    initial begin
        logic [31:0] wdata;
        logic [31:0] rd_data;
        logic        err;
        seed       = 49;
        rstn       = 1'b0;
        req_vld    = 1'b0;
        mst_req    = '0;
        sync_reset = 1'b0;
        ext_rsp    = '0;
        for (int i = 0; i < NUM_REGS; i++) sb[i] = '0;
        for (int i = 0; i < 256; i++) ext_mem[i] = 32'hE500_0000 | (i * 32'h0001_0003);
        load_table();
        repeat (2) @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);
        assert (idle && !ext_req_vld) else stop_with_error("DUT not idle after reset");
        for (int n = 0; n < NUM_ROWS; n++) begin
            if (rows[n].op == OP_SYNC) begin
                apply_sync_reset(rows[n]);
            end else begin
                wdata = rows[n].rnd ? $random(seed) : rows[n].wr_data;
                run_access(rows[n], wdata, rd_data, err);
                check_value("mst_rsp.rd_data", rd_data,
                            rows[n].from_model ? model_data(rows[n]) : rows[n].exp_data);
                check_value("mst_rsp.err", 32'(err), 32'(rows[n].exp_err));
                if (rows[n].op == OP_WR && !rows[n].addr[15] && !rows[n].exp_err &&
                    rows[n].addr[14:2] != '0) sb[rows[n].addr[4:2]] = wdata;
            end
        end
        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- reg_slv.f
common/reg_pkg.sv
slv_fsm/slv_fsm.sv
verilog/ack_timer.sv
verilog/reg_decoder.sv
verilog/int_reg_file.sv
verilog/reg_slv_top.sv
sim/tb_reg_slv.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_reg_slv \
    -f reg_slv.f -o sim_reg_slv

out=$(./obj_dir/sim_reg_slv 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "Finished with no errors"; then
    exit 0
fi
exit 1
